//--- project.f
common/float_pkg.sv
common/neuron_pkg.sv
common/float_stream_if.sv
src/weight_multiplier.sv
sigmoid/sigmoid_lut.sv
src/stream_skid.sv
src/neural_stage_top.sv
testbench/neural_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module neural_stage_tb \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vneural_stage_tb > sim.log 2>&1 \
  || echo "Build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "^Testbench passed$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- testbench/neural_stage_tb.sv
// Neural stage testbench with reference model, stimulus and assertion checks
`timescale 1ns/1ps
`default_nettype none

module neural_stage_tb
  import float_pkg::*, neuron_pkg::*;
();

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  logic                 in_ready;
  opcode_t              in_opcode;
  logic [tag_width-1:0] in_tag;
  float_24_8            in_data;
  logic                 out_valid;
  logic                 out_ready;
  logic [tag_width-1:0] out_tag;
  float_24_8            out_data;

  integer               seed = 32'h74869f8a;
  logic [31:0]          w_model [weight_count];
  logic [31:0]          exp_q [$];
  logic [tag_width-1:0] tag_q [$];
  int                   acc_q [$];
  int                   cycle = 0;
  int                   mismatch_count = 0;
  int                   other_count = 0;
  int                   timeout_count;
  bit                   hung;
  bit                   check_latency;
  bit                   toggle_ready;
  bit                   sat_phase;
  bit                   ready_was_low = 1'b0;
  bit                   was_reset = 1'b0;
  logic [31:0]          x;

  neural_stage_top u_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_opcode (in_opcode),
    .in_tag    (in_tag),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_tag   (out_tag),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Downstream ready is random while back-pressure is exercised
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      if (toggle_ready) begin
        out_ready <= 1'($random(seed));
      end else begin
        out_ready <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Exact only for power-of-two weights
  function automatic logic [31:0] product_model(input logic [31:0] a, input logic [31:0] w);
    int e;
    e = int'(a[30:23]) + int'(w[30:23]) - 127;
    if (a[30:23] == 8'd0 || w[30:23] == 8'd0 || e < 1) begin
      return 32'd0;
    end
    if (e > 254) begin
      e = 254;
    end
    return {a[31] ^ w[31], 8'(e), a[22:0]};
  endfunction

  function automatic logic [31:0] sigmoid_model(input logic [31:0] p);
    logic        s;
    logic [7:0]  e;
    logic [22:0] m;
    logic [7:0]  re;
    logic [22:0] rm;
    s  = p[31];
    e  = p[30:23];
    m  = p[22:0];
    re = s ? 8'd125 : 8'd126;
    if (e > 8'd129) begin
      re = s ? 8'd0 : 8'd127;
      rm = 23'd0;
    end else if (e == 8'd129) begin
      rm = s ? 23'd0 : {4'he, m[22:4]};
      if (s) begin
        // First zero among the top four mantissa bits
        casez (m[22:19])
          4'b0???: re = 8'd121;
          4'b10??: re = 8'd120;
          4'b110?: re = 8'd119;
          4'b1110: re = 8'd118;
          default: re = 8'd0;
        endcase
      end
    end else begin
      case (e)
        8'd128: begin
          re = s ? (m[22] ? 8'd122 : 8'd123) : 8'd126;
          rm = s ? {~m[21:0], 1'b0} : {3'h6, m[22:3]};
        end
        8'd127: begin
          re = s ? 8'd124 : 8'd126;
          rm = s ? ~m : {2'h2, m[22:2]};
        end
        8'd126:  rm = s ? {1'b0, ~m[22:1]} : {2'h1, m[22:2]};
        8'd125:  rm = s ? {2'h2, ~m[22:2]} : {3'h1, m[22:3]};
        8'd124:  rm = s ? {3'h6, ~m[22:3]} : {4'h1, m[22:4]};
        default: rm = s ? {4'he, ~m[22:4]} : {5'h1, m[22:5]};
      endcase
    end
    return {1'b0, re, rm};
  endfunction

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  // Input chosen so the product exponent lands in lo .. lo+span-1
  task automatic make_input(input int tag, input int lo, input int span, output logic [31:0] a);
    int          pe;
    int          xe;
    logic        sgn;
    logic [22:0] man;
    pe  = lo + int'($unsigned($random(seed)) % span);
    xe  = pe - int'(w_model[tag][30:23]) + 127;
    sgn = 1'($random(seed));
    man = 23'($random(seed));
    a   = {sgn, 8'(xe), man};
  endtask

  // Leaves the command presented until the next call or release_input
  task automatic send_cmd(input opcode_t op, input logic [tag_width-1:0] tag,
                          input logic [31:0] data);
    int          n;
    logic [31:0] p;
    @(posedge clk);
    in_valid  <= 1'b1;
    in_opcode <= op;
    in_tag    <= tag;
    in_data   <= data;
    n = 0;
    @(negedge clk);
    while (!in_ready && !hung) begin
      n++;
      if (n > 100) begin
        hung = 1'b1;
        timeout_count++;
        $display("Timeout: in_ready stayed low for 100 cycles");
      end
      @(negedge clk);
    end
    if (op == op_eval) begin
      p = product_model(data, w_model[tag]);
      if (sat_phase) begin
        exp_q.push_back(p[31] ? 32'h0000_0000 : 32'h3f80_0000);
      end else begin
        exp_q.push_back(sigmoid_model(p));
      end
      tag_q.push_back(tag);
      acc_q.push_back(cycle + 1);
    end else begin
      w_model[tag] = data;
    end
  endtask

  task automatic release_input();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && !hung) begin
      @(negedge clk);
      n++;
      if (n > 200) begin
        hung = 1'b1;
        timeout_count++;
        $display("Timeout: results still pending after 200 cycles");
      end
    end
  endtask

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    mismatch_count++;
    $display("mismatch at %0t: %s expected %h, actual %h", $time, name, want, got);
  endtask

  task automatic report_failure(input string what);
    other_count++;
    $display("Error at %0t: %s", $time, what);
  endtask

  always @(negedge clk) begin
    logic [31:0]          got;
    logic [31:0]          want;
    logic [tag_width-1:0] want_tag;
    int                   acc;
    if (!reset) begin
      got = out_data;
      if (was_reset) begin
        assert (in_ready) else report_failure("in_ready is low right after reset");
        assert (!out_valid) else report_failure("out_valid is high right after reset");
      end
      // A full pipeline needs out_ready low on the previous cycle
      if (!in_ready) begin
        assert (ready_was_low) else report_failure("in_ready fell while out_ready was high");
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          report_failure("an output appeared with no pending result");
        end else begin
          want     = exp_q.pop_front();
          want_tag = tag_q.pop_front();
          acc      = acc_q.pop_front();
          assert (out_tag == want_tag)
            else report_mismatch("out_tag", 32'(want_tag), 32'(out_tag));
          assert (got == want) else report_mismatch("out_data", want, got);
          assert (!got[31]) else report_mismatch("out_data.sgn", 32'd0, 32'(got[31]));
          if (check_latency) begin
            assert (cycle - acc == 1) else report_mismatch("latency", 32'd1, 32'(cycle - acc));
          end
        end
      end
    end
    ready_was_low = !out_ready;
    was_reset     = reset;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    reset         = 1'b1;
    in_valid      = 1'b0;
    in_opcode     = op_load_weight;
    in_tag        = '0;
    in_data       = float_zero;
    hung          = 1'b0;
    check_latency = 1'b1;
    toggle_ready  = 1'b0;
    sat_phase     = 1'b0;
    timeout_count = 0;
    for (int t = 0; t < weight_count; t++) begin
      w_model[t] = 32'd0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // Weights still zero from reset
    send_cmd(op_eval, tag_width'(5), 32'h3fc0_0000);
    release_input();
    wait_drain();

    // Power-of-two weights and then single evaluations
    for (int t = 0; t < weight_count; t++) begin
      send_cmd(op_load_weight, tag_width'(t), {t >= 8, 8'(125 + t % 5), 23'd0});
    end
    release_input();
    for (int i = 0; i < 8; i++) begin
      make_input(i * 2, 122, 8, x);
      send_cmd(op_eval, tag_width'(i * 2), x);
      release_input();
      wait_drain();
    end

    // Random exponents 100 to 135 back to back
    for (int i = 0; i < 40; i++) begin
      make_input(i % 16, 100, 36, x);
      send_cmd(op_eval, tag_width'(i % 16), x);
    end
    release_input();
    wait_drain();

    // Saturation with both product signs
    sat_phase = 1'b1;
    for (int i = 0; i < 12; i++) begin
      make_input(i % 16, 130, 10, x);
      x[31] = i[0] ^ w_model[i % 16][31];
      send_cmd(op_eval, tag_width'(i % 16), x);
    end
    release_input();
    wait_drain();
    sat_phase = 1'b0;

    // Burst under random back-pressure
    toggle_ready  = 1'b1;
    check_latency = 1'b0;
    for (int i = 0; i < 40; i++) begin
      make_input(i % 16, 110, 22, x);
      send_cmd(op_eval, tag_width'(i % 16), x);
    end
    release_input();
    toggle_ready = 1'b0;
    wait_drain();
    check_latency = 1'b1;

    // Load between evaluations on the same tag
    make_input(3, 110, 20, x);
    send_cmd(op_eval, tag_width'(3), x);
    send_cmd(op_load_weight, tag_width'(3), {1'b1, 8'd126, 23'd0});
    make_input(3, 110, 20, x);
    send_cmd(op_eval, tag_width'(3), x);
    release_input();
    wait_drain();

    repeat (4) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
             mismatch_count, other_count, timeout_count);
    if (mismatch_count == 0 && other_count == 0 && timeout_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/neural_stage_top.sv
// Neural stage top level with multiplier, sigmoid and output buffer
`timescale 1ns/1ps
`default_nettype none

module neural_stage_top
  import float_pkg::*, neuron_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,

  // Command stream
  input  logic                 in_valid,
  output logic                 in_ready,
  input  opcode_t              in_opcode,
  input  logic [tag_width-1:0] in_tag,
  input  float_24_8            in_data,

  // Result stream
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [tag_width-1:0] out_tag,
  output float_24_8            out_data
);

  // Pre-activation products
  float_stream_if product_stream ();

  // Sigmoid results
  float_stream_if activation_stream ();

  weight_multiplier u_weight_multiplier (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_opcode (in_opcode),
    .in_tag    (in_tag),
    .in_data   (in_data),
    .product   (product_stream.source)
  );

  sigmoid_lut u_sigmoid_lut (
    .clk   (clk),
    .reset (reset),
    .pre   (product_stream.sink),
    .act   (activation_stream.source)
  );

  stream_skid u_stream_skid (
    .clk       (clk),
    .reset     (reset),
    .in        (activation_stream.sink),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_tag   (out_tag),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

//--- src/stream_skid.sv
// Two-entry output FIFO with bypass when empty
`timescale 1ns/1ps
`default_nettype none

module stream_skid
  import float_pkg::*, neuron_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  float_stream_if.sink         in,
  output logic                 out_valid,
  input  logic                 out_ready,
  output logic [tag_width-1:0] out_tag,
  output float_24_8            out_data
);

  float_24_8            data_mem [2];
  logic [tag_width-1:0] tag_mem [2];
  logic                 rd_ptr;
  logic                 wr_ptr;
  logic [1:0]           count;
  logic                 empty;
  logic                 bypass;
  logic                 push;
  logic                 pop;

  assign empty = count == 2'd0;

  // Occupancy only, no path from out_ready
  assign in.ready = count != 2'd2;

  // Empty and taken straight away, nothing is stored
  assign bypass = empty && out_ready;
  assign push   = in.valid && in.ready && !bypass;
  assign pop    = !empty && out_ready;

  assign out_valid = !empty || in.valid;
  assign out_tag   = empty ? in.tag : tag_mem[rd_ptr];
  assign out_data  = empty ? in.data : data_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= 1'b0;
      wr_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      count <= count + 2'(push) - 2'(pop);
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= in.data;
      tag_mem[wr_ptr]  <= in.tag;
    end
  end

endmodule

`default_nettype wire

//--- sigmoid/sigmoid_lut.sv
// Piecewise-linear sigmoid lookup with registered output, tag and valid
`timescale 1ns/1ps
`default_nettype none

module sigmoid_lut
  import float_pkg::*;
(
  input logic          clk,
  input logic          reset,
  float_stream_if.sink   pre,
  float_stream_if.source act
);

  float_24_8   x;
  logic [7:0]  sig_exp;
  logic [22:0] sig_man;
  float_24_8   sig;

  assign x = pre.data;

  // Stage moves when its output slot is empty or being taken
  assign pre.ready = !act.valid || act.ready;

  // ----------------------------------------
  // Exponent table
  // ----------------------------------------
  always_comb begin
    if (x.exp > 8'd129) begin
      sig_exp = x.sgn ? float_zero.exp : float_one.exp;
    end else if (x.exp == 8'd129) begin
      if (!x.sgn) begin
        sig_exp = 8'd126;
      end else if (!x.man[22]) begin
        sig_exp = 8'd121;
      end else if (!x.man[21]) begin
        sig_exp = 8'd120;
      end else if (!x.man[20]) begin
        sig_exp = 8'd119;
      end else if (!x.man[19]) begin
        sig_exp = 8'd118;
      end else begin
        // Deep negative tail flushes to zero
        sig_exp = 8'd0;
      end
    end else if (x.exp == 8'd128) begin
      if (x.sgn) begin
        sig_exp = x.man[22] ? 8'd122 : 8'd123;
      end else begin
        sig_exp = 8'd126;
      end
    end else if (x.exp == 8'd127) begin
      sig_exp = x.sgn ? 8'd124 : 8'd126;
    end else begin
      // Small x sits near one half
      sig_exp = x.sgn ? 8'd125 : 8'd126;
    end
  end

  // ----------------------------------------
  // Mantissa table
  // ----------------------------------------
  always_comb begin
    if (x.exp > 8'd129) begin
      sig_man = 23'd0;
    end else if (x.exp == 8'd129) begin
      sig_man = x.sgn ? 23'd0 : {4'he, x.man[22:4]};
    end else if (x.exp == 8'd128) begin
      sig_man = x.sgn ? {~x.man[21:0], 1'b0} : {3'h6, x.man[22:3]};
    end else if (x.exp == 8'd127) begin
      sig_man = x.sgn ? ~x.man : {2'h2, x.man[22:2]};
    end else if (x.exp == 8'd126) begin
      sig_man = x.sgn ? {1'h0, ~x.man[22:1]} : {2'h1, x.man[22:2]};
    end else if (x.exp == 8'd125) begin
      sig_man = x.sgn ? {2'h2, ~x.man[22:2]} : {3'h1, x.man[22:3]};
    end else if (x.exp == 8'd124) begin
      sig_man = x.sgn ? {3'h6, ~x.man[22:3]} : {4'h1, x.man[22:4]};
    end else begin
      // Five place shift below 124
      sig_man = x.sgn ? {4'he, ~x.man[22:4]} : {5'h1, x.man[22:5]};
    end
  end

  // Sigmoid output is never negative
  assign sig = '{sgn: 1'b0, exp: sig_exp, man: sig_man};

  always_ff @(posedge clk) begin
    if (reset) begin
      act.valid <= 1'b0;
    end else if (pre.ready) begin
      act.valid <= pre.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pre.valid && pre.ready) begin
      act.tag  <= pre.tag;
      act.data <= sig;
    end
  end

endmodule

`default_nettype wire

//--- src/weight_multiplier.sv
// Weight bank and registered float multiply of the input by the tagged weight
`timescale 1ns/1ps
`default_nettype none

module weight_multiplier
  import float_pkg::*, neuron_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  opcode_t              in_opcode,
  input  logic [tag_width-1:0] in_tag,
  input  float_24_8            in_data,
  float_stream_if.source       product
);

  float_24_8         weights [weight_count];
  float_24_8         weight;
  float_24_8         result;
  logic [47:0]       man_prod;
  logic signed [9:0] exp_sum;
  logic              accept;
  logic              is_eval;

  // Advance when the product register is free or drains this cycle
  assign in_ready = !product.valid || product.ready;
  assign accept   = in_valid && in_ready;
  assign is_eval  = in_opcode == op_eval;

  // Bank read is combinational so a load lands before the next eval
  assign weight = weights[in_tag];

  // ----------------------------------------
  // Float multiply, truncating
  // ----------------------------------------

  // Both mantissas with hidden ones, 24 x 24 bits
  assign man_prod = {1'b1, in_data.man} * {1'b1, weight.man};

  // Top product bit set means normalize up by one
  assign exp_sum = 10'(in_data.exp) + 10'(weight.exp) + 10'(man_prod[47])
                 - 10'(float_bias);

  always_comb begin
    result.sgn = in_data.sgn ^ weight.sgn;
    result.exp = exp_sum[7:0];
    result.man = man_prod[47] ? man_prod[46:24] : man_prod[45:23];
    if (in_data.exp == 8'd0 || weight.exp == 8'd0 || exp_sum < 10'sd1) begin
      // Zero operand or underflow
      result = float_zero;
    end else if (exp_sum > $signed(10'(float_exp_max))) begin
      result.exp = 8'(float_exp_max);
    end
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      product.valid <= 1'b0;
      for (int i = 0; i < weight_count; i++) begin
        weights[i] <= float_zero;
      end
    end else begin
      // Loads take a slot but emit nothing
      if (in_ready) begin
        product.valid <= in_valid && is_eval;
      end
      if (accept && !is_eval) begin
        weights[in_tag] <= in_data;
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (accept && is_eval) begin
      product.tag  <= in_tag;
      product.data <= result;
    end
  end

endmodule

`default_nettype wire

//--- common/float_stream_if.sv
// Tagged float stream interface with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface float_stream_if
  import float_pkg::*, neuron_pkg::*;
();

  logic                 valid;
  logic                 ready;
  logic [tag_width-1:0] tag;
  float_24_8            data;

  // Producer side
  modport source (output valid, output tag, output data, input ready);

  // Consumer side
  modport sink (input valid, input tag, input data, output ready);

endinterface

`default_nettype wire

//--- common/neuron_pkg.sv
// Command opcode enum, tag width and weight count
`default_nettype none

package neuron_pkg;

  // ----------------------------------------
  // Command stream
  // ----------------------------------------

  // Load writes the weight bank, eval runs multiply and sigmoid
  typedef enum logic {
    op_load_weight = 1'b0,
    op_eval        = 1'b1
  } opcode_t;

  // Tag picks the weight and comes back with the result
  localparam int tag_width = 4;

  // One weight per tag value
  localparam int weight_count = 16;

endpackage

`default_nettype wire

//--- common/float_pkg.sv
// Float number type, exponent limits and float constants
`default_nettype none

package float_pkg;

  // ----------------------------------------
  // Single precision layout
  // ----------------------------------------

  // Sign, biased exponent, mantissa without the hidden one
  typedef struct packed {
    logic        sgn;
    logic [7:0]  exp;
    logic [22:0] man;
  } float_24_8;

  // Exponent bias
  localparam int float_bias = 127;

  // Largest exponent kept, overflow saturates here
  localparam int float_exp_max = 254;

  // ----------------------------------------
  // Constants
  // ----------------------------------------

  // Exponent zero counts as zero, no denormals
  localparam float_24_8 float_zero = '{sgn: 1'b0, exp: 8'd0, man: 23'd0};

  localparam float_24_8 float_one = '{sgn: 1'b0, exp: 8'd127, man: 23'd0};

endpackage

`default_nettype wire
